// File: source/segway_phys_pkg.sv
`default_nettype none

package segway_phys_pkg;

  //////////////////////////////
  // numeric types of the platform model
  //////////////////////////////
  typedef logic signed [11:0] duty_t;   // signed motor drive, fwd minus rev
  typedef logic signed [15:0] torque_t;
  typedef logic signed [15:0] omega_t;  // platform angular velocity
  typedef logic signed [15:0] theta_t;  // platform angle
  typedef logic [15:0] sample_t;        // raw sensor word as seen in the map

  // pulse counters and silence timers
  localparam int cnt_w = 11;
  localparam int idle_w = 12;           // msb set means 2048 quiet cycles

  //////////////////////////////
  // torque curve
  //////////////////////////////
  localparam logic [11:0] min_duty = 12'h38E;   // edge of the dead zone
  localparam logic [4:0] torque_gain = 5'd14;   // slope outside the dead zone

  // sensor output scaling
  localparam sample_t az_offset = 16'h00A0;
  localparam sample_t ptch_rt_offset = 16'h0050;
  localparam logic signed [4:0] ptch_rt_gain = -5'sd12;

endpackage

`default_nettype wire

// File: source/imu_pkg.sv
`default_nettype none

package imu_pkg;

  typedef logic [6:0] reg_addr_t;   // 128 byte register map
  typedef logic [7:0] reg_data_t;

  //////////////////////////////
  // sample locations
  //////////////////////////////
  localparam reg_addr_t ptch_lo_addr = 7'h22;   // a read here clears INT
  localparam reg_addr_t ptch_hi_addr = 7'h23;
  localparam reg_addr_t az_lo_addr = 7'h2C;
  localparam reg_addr_t az_hi_addr = 7'h2D;

  // both must hold their values before samples are flagged
  localparam reg_addr_t setup_a_addr = 7'h0D;
  localparam reg_data_t setup_a_val = 8'h02;
  localparam reg_addr_t setup_b_addr = 7'h11;
  localparam reg_data_t setup_b_val = 8'h50;

  localparam reg_data_t write_resp = 8'hA5;   // 2nd byte of a write frame
  localparam int odr_div = 1024;              // clk cycles per INT event
  localparam int frame_bits = 16;             // cmd byte + data byte

endpackage

`default_nettype wire

// File: source/reg_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

// four phase req/ack link from the SPI slave to the register block
interface reg_bus_if;
  import imu_pkg::*;

  logic req;          // held until ack seen
  logic we;
  reg_addr_t addr;
  reg_data_t wdata;   // on a read this carries the whole command byte
  logic ack;          // dropped once req is gone
  reg_data_t rdata;

  modport master (output req, output we, output addr, output wdata,
                  input ack, input rdata);
  modport slave (input req, input we, input addr, input wdata,
                 output ack, output rdata);

endinterface

`default_nettype wire

// File: source/pwm_duty_meter.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_duty_meter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pwm_fwd,
  input  logic                   pwm_rev,
  output segway_phys_pkg::duty_t duty,
  output logic                   active
);
  import segway_phys_pkg::*;

  logic fwd_q, rev_q;               // last cycle's pwm levels
  logic rise, fall;
  logic [cnt_w-1:0] fwd_cnt;        // high time of the forward line
  logic [cnt_w-1:0] rev_cnt;
  logic [idle_w-1:0] silence;       // cycles since the last rise

  assign rise = (pwm_fwd & ~fwd_q) | (pwm_rev & ~rev_q);
  assign fall = (~pwm_fwd & fwd_q) | (~pwm_rev & rev_q);
  assign active = pwm_fwd | pwm_rev;    // physics waits for all of these to drop

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_q <= 1'b0;
      rev_q <= 1'b0;
    end else begin
      fwd_q <= pwm_fwd;
      rev_q <= pwm_rev;
    end
  end

  //////////////////////////////
  // high time counters
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fwd_cnt <= '0;
      rev_cnt <= '0;
    end else if (rise) begin
      fwd_cnt <= cnt_w'(1);   // the rising cycle already counts
      rev_cnt <= cnt_w'(1);
    end else begin
      if (pwm_fwd) fwd_cnt <= fwd_cnt + 1'b1;
      if (pwm_rev) rev_cnt <= rev_cnt + 1'b1;
    end
  end

  // saturates once the msb is reached
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      silence <= '0;
    else if (rise)
      silence <= '0;
    else if (!silence[idle_w-1])
      silence <= silence + 1'b1;
  end

  // duty latched on the cycle after a fall, zeroed after a long quiet spell
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      duty <= '0;
    else if (silence[idle_w-1])
      duty <= '0;
    else if (fall)
      duty <= {1'b0, fwd_cnt} - {1'b0, rev_cnt};
  end

endmodule

`default_nettype wire

// File: source/platform_physics.sv
`timescale 1ns/10ps
`default_nettype none

module platform_physics (
  input  logic                     clk,
  input  logic                     rst_n,
  input  segway_phys_pkg::duty_t   duty_lft,
  input  segway_phys_pkg::duty_t   duty_rght,
  input  logic                     active_lft,
  input  logic                     active_rght,
  input  logic signed [15:0]       rider_lean,
  output segway_phys_pkg::sample_t az,
  output segway_phys_pkg::sample_t ptch_rate,
  output logic                     step_done
);
  import segway_phys_pkg::*;

  logic any_active, any_active_q;
  logic last_fall;                  // final pwm line of both motors dropped
  logic step;                       // integrate on the next edge
  logic [idle_w-1:0] idle_tmr;
  torque_t torque_lft, torque_rght, net_torque;
  omega_t omega, omega_nxt, friction;
  theta_t theta, theta_nxt, theta_scl;
  logic signed [19:0] rate_prod;

  // dead zone curve, gain steps up past min_duty
  function automatic torque_t duty2torque(input duty_t duty);
    logic signed [12:0] d_ext;
    logic [12:0] mag;
    logic [16:0] t_abs;
    d_ext = duty;
    mag = d_ext[12] ? -d_ext : d_ext;
    if (mag > min_duty)
      t_abs = torque_gain * (mag - min_duty) + min_duty;
    else
      t_abs = {4'b0, mag};
    duty2torque = d_ext[12] ? -$signed(t_abs[16:1]) : $signed(t_abs[16:1]);
  endfunction

  //////////////////////////////
  // step scheduling
  //////////////////////////////
  assign any_active = active_lft | active_rght;
  assign last_fall = any_active_q & ~any_active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      any_active_q <= 1'b0;
      idle_tmr <= '0;
      step <= 1'b0;
      step_done <= 1'b0;
    end else begin
      any_active_q <= any_active;
      if (step || idle_tmr[idle_w-1])
        idle_tmr <= '0;             // restart after every step
      else
        idle_tmr <= idle_tmr + 1'b1;
      step <= last_fall | idle_tmr[idle_w-1];   // idle step keeps the model moving
      step_done <= step;            // new state is visible with this pulse
    end
  end

  //////////////////////////////
  // one integration step
  //////////////////////////////
  assign torque_lft = duty2torque(duty_lft);
  assign torque_rght = duty2torque(duty_rght);
  assign net_torque = rider_lean - torque_lft - torque_rght;

  always_comb begin
    if (omega > 16'sh0400 || omega < -16'sh0400)
      friction = omega >>> 10;      // viscous above the knee
    else if (omega < 16'sd0)
      friction = -16'sd1;
    else if (omega == 16'sd0)
      friction = 16'sd0;
    else
      friction = 16'sd1;
  end

  assign omega_nxt = omega + (net_torque >>> 3) - friction;
  assign theta_nxt = theta + (omega_nxt >>> 6);   // angle uses the fresh rate

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      omega <= '0;
      theta <= '0;
    end else if (step) begin
      omega <= omega_nxt;
      theta <= theta_nxt;
    end
  end

  // sensor view of the state
  assign theta_scl = theta >>> 3;
  assign az = theta_scl + az_offset;
  assign rate_prod = omega * ptch_rt_gain;          // 20 bit product
  assign ptch_rate = rate_prod[19:4] + ptch_rt_offset;

endmodule

`default_nettype wire

// File: source/imu_spi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module imu_spi_slave (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ss_n,
  input  logic      sclk,
  input  logic      mosi,
  output logic      miso,
  reg_bus_if.master bus
);
  import imu_pkg::*;

  localparam int bit_w = $clog2(frame_bits + 1);
  localparam logic [bit_w-1:0] half_cnt = bit_w'(frame_bits / 2);

  typedef enum logic [1:0] {idle, cmd_half, data_half} frame_state_t;

  frame_state_t state;
  logic [1:0] ss_sync;
  logic [2:0] sclk_sync;            // 3rd stage for edge detect
  logic [1:0] mosi_sync;
  logic ss_act, sclk_rise, sclk_fall, mosi_s;
  logic [bit_w-1:0] bit_cnt;        // rising edges seen this frame
  logic [frame_bits-1:0] rx_shft;
  logic [frame_bits-1:0] tx_shft;
  reg_data_t cmd_byte, resp;
  logic rd_issue, wr_issue;
  logic pend;                       // request waiting for ack to clear

  //////////////////////////////
  // input synchronizers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ss_sync <= 2'b11;             // deselected
      sclk_sync <= '0;
      mosi_sync <= '0;
    end else begin
      ss_sync <= {ss_sync[0], ss_n};
      sclk_sync <= {sclk_sync[1:0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign ss_act = ~ss_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
  assign mosi_s = mosi_sync[1];     // same delay as sclk_sync[1]

  //////////////////////////////
  // frame controller
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        idle: begin
          bit_cnt <= '0;
          if (ss_act) state <= cmd_half;
        end
        cmd_half: begin
          if (!ss_act)
            state <= idle;          // aborted frame
          else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == half_cnt - 1'b1) state <= data_half;
          end
        end
        data_half: begin
          if (!ss_act)
            state <= idle;
          else if (sclk_rise)
            bit_cnt <= bit_cnt + 1'b1;
        end
        default: state <= idle;
      endcase
    end
  end

  // read goes out on the 8th rise, write at SS_n rise for a full write frame
  assign cmd_byte = {rx_shft[6:0], mosi_s};
  assign rd_issue = (state == cmd_half) && ss_act && sclk_rise &&
                    (bit_cnt == half_cnt - 1'b1);
  assign wr_issue = (state == data_half) && !ss_act && !rx_shft[15] &&
                    (bit_cnt == bit_w'(frame_bits));

  // rx samples on rise, tx shifts on fall
  always_ff @(posedge clk) begin
    if (state != idle && ss_act && sclk_rise)
      rx_shft <= {rx_shft[frame_bits-2:0], mosi_s};
    if (state == idle)
      tx_shft <= '0;
    else if (sclk_fall) begin
      if (state == data_half && bit_cnt == half_cnt)
        tx_shft <= {resp, {(frame_bits - 8){1'b0}}};   // reply msb before 9th rise
      else
        tx_shft <= {tx_shft[frame_bits-2:0], 1'b0};
    end
  end

  assign miso = ~ss_n & tx_shft[frame_bits-1];   // low while deselected

  //////////////////////////////
  // register bus master
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend <= 1'b0;
      bus.req <= 1'b0;
      bus.we <= 1'b0;
      bus.addr <= '0;
      bus.wdata <= '0;
      resp <= '0;
    end else if (rd_issue || wr_issue) begin
      pend <= 1'b1;
      bus.we <= wr_issue;
      bus.addr <= wr_issue ? rx_shft[14:8] : cmd_byte[6:0];
      bus.wdata <= wr_issue ? rx_shft[7:0] : cmd_byte;
    end else if (pend && !bus.req && !bus.ack) begin
      pend <= 1'b0;
      bus.req <= 1'b1;
    end else if (bus.req && bus.ack) begin
      bus.req <= 1'b0;              // slave drops ack next
      if (!bus.we) resp <= bus.rdata;
    end
  end

endmodule

`default_nettype wire

// File: source/imu_reg_block.sv
`timescale 1ns/10ps
`default_nettype none

module imu_reg_block (
  input  logic                     clk,
  input  logic                     rst_n,
  reg_bus_if.slave                 bus,
  input  segway_phys_pkg::sample_t az,
  input  segway_phys_pkg::sample_t ptch_rate,
  input  logic                     step_done,
  output logic                     int_out
);
  import imu_pkg::*;
  import segway_phys_pkg::*;

  localparam int odr_w = $clog2(odr_div);

  reg_data_t regs [2**$bits(reg_addr_t)];
  logic access;                     // first cycle of a request
  logic acc_q;
  logic setup;
  logic int_clr;
  logic [odr_w-1:0] odr_cnt;

  //////////////////////////////
  // handshake, ack 2 cycles after req
  //////////////////////////////
  assign access = bus.req & ~bus.ack & ~acc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= 1'b0;
      bus.ack <= 1'b0;
    end else begin
      acc_q <= access;
      if (acc_q)
        bus.ack <= 1'b1;
      else if (!bus.req)
        bus.ack <= 1'b0;
    end
  end

  // a write command echoes write_resp in place of data
  always_ff @(posedge clk) begin
    if (access)
      bus.rdata <= bus.wdata[7] ? regs[bus.addr] : write_resp;
  end

  //////////////////////////////
  // register file
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**$bits(reg_addr_t); i++)
        regs[i] <= '0;
      regs[az_lo_addr] <= az_offset[7:0];     // integrators start at zero
      regs[az_hi_addr] <= az_offset[15:8];
      regs[ptch_lo_addr] <= ptch_rt_offset[7:0];
      regs[ptch_hi_addr] <= ptch_rt_offset[15:8];
    end else begin
      if (step_done) begin
        regs[az_lo_addr] <= az[7:0];
        regs[az_hi_addr] <= az[15:8];
        regs[ptch_lo_addr] <= ptch_rate[7:0];
        regs[ptch_hi_addr] <= ptch_rate[15:8];
      end
      if (access && bus.we)
        regs[bus.addr] <= bus.wdata;
    end
  end

  //////////////////////////////
  // output data rate and INT
  //////////////////////////////
  assign setup = (regs[setup_a_addr] == setup_a_val) &&
                 (regs[setup_b_addr] == setup_b_val);
  assign int_clr = access && !bus.we && bus.wdata[7] && (bus.addr == ptch_lo_addr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      odr_cnt <= '0;
      int_out <= 1'b0;
    end else begin
      if (!setup)
        odr_cnt <= '0;              // held until configured
      else if (odr_cnt == odr_w'(odr_div - 1))
        odr_cnt <= '0;
      else
        odr_cnt <= odr_cnt + 1'b1;
      if (int_clr)
        int_out <= 1'b0;            // pitch rate low byte read
      else if (setup && odr_cnt == odr_w'(odr_div - 1))
        int_out <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: source/segway_imu.sv
`timescale 1ns/10ps
`default_nettype none

module segway_imu (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ss_n,
  input  logic               sclk,
  input  logic               mosi,
  output logic               miso,
  output logic               int_out,
  input  logic               pwm1_lft,   // forward
  input  logic               pwm2_lft,   // reverse
  input  logic               pwm1_rght,
  input  logic               pwm2_rght,
  input  logic signed [15:0] rider_lean
);
  import segway_phys_pkg::*;

  duty_t duty_lft, duty_rght;
  logic active_lft, active_rght;
  sample_t az, ptch_rate;
  logic step_done;

  reg_bus_if u_bus ();

  //////////////////////////////
  // motor side
  //////////////////////////////
  pwm_duty_meter u_meter_lft (
    .clk     (clk),
    .rst_n   (rst_n),
    .pwm_fwd (pwm1_lft),
    .pwm_rev (pwm2_lft),
    .duty    (duty_lft),
    .active  (active_lft)
  );

  pwm_duty_meter u_meter_rght (
    .clk     (clk),
    .rst_n   (rst_n),
    .pwm_fwd (pwm1_rght),
    .pwm_rev (pwm2_rght),
    .duty    (duty_rght),
    .active  (active_rght)
  );

  platform_physics u_physics (
    .clk         (clk),
    .rst_n       (rst_n),
    .duty_lft    (duty_lft),
    .duty_rght   (duty_rght),
    .active_lft  (active_lft),
    .active_rght (active_rght),
    .rider_lean  (rider_lean),
    .az          (az),
    .ptch_rate   (ptch_rate),
    .step_done   (step_done)
  );

  //////////////////////////////
  // sensor side
  //////////////////////////////
  imu_spi_slave u_spi (
    .clk   (clk),
    .rst_n (rst_n),
    .ss_n  (ss_n),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .bus   (u_bus.master)
  );

  imu_reg_block u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (u_bus.slave),
    .az        (az),
    .ptch_rate (ptch_rate),
    .step_done (step_done),
    .int_out   (int_out)
  );

endmodule

`default_nettype wire

// File: include/tb_segway_tasks.svh
`ifndef TB_SEGWAY_TASKS_SVH
`define TB_SEGWAY_TASKS_SVH

//////////////////////////////
// pin drivers
//////////////////////////////

// wait n clock edges and step off the last one before driving
task automatic tick(input int n);
  repeat (n) begin
    @(posedge clk);
    #10;
  end
endtask

// mode 0 frame with mosi set while sclk is low and miso taken just before each rise
task automatic spi_xfer(input logic [15:0] tx, output logic [15:0] rx);
  rx = '0;
  ss_n = 1'b0;
  tick(sclk_half);
  for (int i = frame_bits - 1; i >= 0; i--) begin
    mosi = tx[i];
    tick(sclk_half);
    rx[i] = miso;
    sclk = 1'b1;
    tick(sclk_half);
    sclk = 1'b0;
  end
  tick(sclk_half);
  ss_n = 1'b1;                        // write request goes out here
  mosi = 1'b0;
  tick(2 * sclk_half);
endtask

task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
  logic [15:0] rx;
  spi_xfer({1'b1, addr, 8'h00}, rx);
  data = rx[7:0];
endtask

task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
  logic [15:0] rx;
  spi_xfer({1'b0, addr, data}, rx);
  check_byte("write response", rx[7:0], write_resp);
endtask

// low byte is read before the high byte
task automatic read_sample(input reg_addr_t lo, input reg_addr_t hi, output sample_t s);
  reg_data_t b_lo;
  reg_data_t b_hi;
  reg_read(lo, b_lo);
  reg_read(hi, b_hi);
  s = {b_hi, b_lo};
endtask

// quiet part first then all rises on one edge and the wait for the step
task automatic pwm_period(input int hf_l, input int hr_l, input int hf_r, input int hr_r,
                          input int period);
  int h_max;
  int n;
  h_max = hf_l;
  if (hr_l > h_max) h_max = hr_l;
  if (hf_r > h_max) h_max = hf_r;
  if (hr_r > h_max) h_max = hr_r;
  tick(period - h_max);
  pwm1_lft = (hf_l > 0);
  pwm2_lft = (hr_l > 0);
  pwm1_rght = (hf_r > 0);
  pwm2_rght = (hr_r > 0);
  for (int k = 1; k <= h_max; k++) begin
    tick(1);                          // k edges seen high so far
    if (k == hf_l) pwm1_lft = 1'b0;
    if (k == hr_l) pwm2_lft = 1'b0;
    if (k == hf_r) pwm1_rght = 1'b0;
    if (k == hr_r) pwm2_rght = 1'b0;
  end
  n = 0;
  while (dut.step_done !== 1'b1 && n < 16) begin
    @(negedge clk);
    n++;
  end
  if (dut.step_done !== 1'b1)
    report_failure("no physics step after the last PWM fall");
  tick(1);                            // map holds the new sample now
endtask

//////////////////////////////
// reference model
//////////////////////////////

// a silent line still counts one since a rise loads both counters with 1
function automatic int measured_duty(input int hf, input int hr);
  measured_duty = ((hf > 1) ? hf : 1) - ((hr > 1) ? hr : 1);
endfunction

function automatic int ref_torque(input int d);
  int a;
  int t;
  int md;
  md = min_duty;
  a = (d < 0) ? -d : d;
  if (a > md)
    t = torque_gain * (a - md) + md;  // steeper outside the dead zone
  else
    t = a;
  t = t / 2;
  ref_torque = (d < 0) ? -t : t;
endfunction

function automatic void ref_step(input int lean, input int duty_l, input int duty_r,
                                 inout omega_t omega, inout theta_t theta);
  int net;
  int om;
  int fr;
  torque_t net_w;
  net = lean - ref_torque(duty_l) - ref_torque(duty_r);
  net_w = net[15:0];                  // 16 bit torque word
  net = net_w;
  om = omega;
  if (om > 1024 || om < -1024)
    fr = om >>> 10;
  else if (om > 0)
    fr = 1;
  else if (om < 0)
    fr = -1;
  else
    fr = 0;
  om = om + (net >>> 3) - fr;
  omega = om[15:0];
  theta = theta + (omega >>> 6);      // angle follows the new rate
endfunction

function automatic sample_t ref_az(input theta_t theta);
  int th;
  th = theta;
  th = th >>> 3;
  ref_az = th[15:0] + az_offset;
endfunction

function automatic sample_t ref_ptch(input omega_t omega);
  int prod;
  prod = omega;
  prod = prod * ptch_rt_gain;
  prod = prod >>> 4;
  ref_ptch = prod[15:0] + ptch_rt_offset;
endfunction

//////////////////////////////
// checks
//////////////////////////////
task automatic report_failure(input string what);
  err_cnt++;
  $display("Error at %0d ns: %s", $time, what);
endtask

task automatic require(input bit cond, input string what);
  chk_cnt++;
  if (!cond) report_failure(what);
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_sample(input string name, input sample_t got, input sample_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_byte(input string name, input reg_data_t got, input reg_data_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

`endif

// File: bench/tb_segway_imu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_segway_imu;
  import segway_phys_pkg::*;
  import imu_pkg::*;

  localparam int sclk_half = 8;       // clk cycles per SCLK half period
  localparam int n_periods = 6;

  logic clk, rst_n;
  logic ss_n, sclk, mosi, miso, int_out;
  logic pwm1_lft, pwm2_lft, pwm1_rght, pwm2_rght;
  logic signed [15:0] rider_lean;

  integer seed;
  int err_cnt, chk_cnt;
  omega_t ref_omega;                  // reference platform state
  theta_t ref_theta;

  // high times per period inside and beyond the dead zone
  int dz_fwd_l [4] = '{500, 1200, 0, 911};
  int dz_rev_l [4] = '{0, 0, 1300, 0};
  int dz_fwd_r [4] = '{0, 1000, 0, 0};
  int dz_rev_r [4] = '{300, 0, 950, 912};

  segway_imu dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .ss_n       (ss_n),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso),
    .int_out    (int_out),
    .pwm1_lft   (pwm1_lft),
    .pwm2_lft   (pwm2_lft),
    .pwm1_rght  (pwm1_rght),
    .pwm2_rght  (pwm2_rght),
    .rider_lean (rider_lean)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  `include "tb_segway_tasks.svh"

  task automatic apply_reset();
    rst_n = 1'b0;
    ss_n = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    {pwm1_lft, pwm2_lft, pwm1_rght, pwm2_rght} = '0;
    rider_lean = '0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    ref_omega = '0;
    ref_theta = '0;
    tick(2);
  endtask

  // poll INT on the falling clock until it reaches level
  task automatic wait_int(input logic level, input int limit, output bit ok);
    int n;
    n = 0;
    while (int_out !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    ok = (int_out === level);
    tick(1);
  endtask

  task automatic hold_int_low(input int cycles, output bit ok);
    ok = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      if (int_out !== 1'b0) ok = 1'b0;
    end
    tick(1);
  endtask

  task automatic finish_test(input string name, input int start);
    if (err_cnt == start)
      $display("test %s: ok", name);
    else
      $display("test %s: failed with %0d errors", name, err_cnt - start);
  endtask

  initial begin
    int start;
    int lean;
    int h_l, h_r;
    reg_data_t wr_val, rd_val;
    sample_t smp;
    bit ok;
    seed = 27212;
    err_cnt = 0;
    chk_cnt = 0;

    ////////////////////////////// reset values
    start = err_cnt;
    apply_reset();
    check_flag("int_out", int_out, 1'b0);
    read_sample(az_lo_addr, az_hi_addr, smp);
    check_sample("az", smp, az_offset);
    read_sample(ptch_lo_addr, ptch_hi_addr, smp);
    check_sample("ptch_rate", smp, ptch_rt_offset);
    finish_test("reset values", start);

    ////////////////////////////// write and read back
    start = err_cnt;
    wr_val = $random(seed);
    reg_write(7'h40, wr_val);         // response byte checked inside
    reg_read(7'h40, rd_val);
    check_byte("reg 0x40", rd_val, wr_val);
    wr_val = $random(seed);
    reg_write(7'h7F, wr_val);
    reg_read(7'h7F, rd_val);
    check_byte("reg 0x7F", rd_val, wr_val);
    finish_test("register write", start);

    ////////////////////////////// zero duty, lean only
    start = err_cnt;
    apply_reset();
    for (int p = 0; p < n_periods; p++) begin
      lean = $random(seed) % 2001;
      h_l = 20 + ($random(seed) & 255);
      h_r = 20 + ($random(seed) & 255);
      rider_lean = lean[15:0];
      pwm_period(h_l, h_l, h_r, h_r, 400);
      ref_step(lean, measured_duty(h_l, h_l), measured_duty(h_r, h_r), ref_omega, ref_theta);
    end
    read_sample(az_lo_addr, az_hi_addr, smp);
    check_sample("az", smp, ref_az(ref_theta));
    read_sample(ptch_lo_addr, ptch_hi_addr, smp);
    check_sample("ptch_rate", smp, ref_ptch(ref_omega));
    finish_test("zero duty with lean", start);

    ////////////////////////////// dead zone with long periods for the wide pulses
    start = err_cnt;
    apply_reset();
    for (int p = 0; p < 4; p++) begin
      lean = $random(seed) % 1001;
      rider_lean = lean[15:0];
      pwm_period(dz_fwd_l[p], dz_rev_l[p], dz_fwd_r[p], dz_rev_r[p], 1500);
      ref_step(lean, measured_duty(dz_fwd_l[p], dz_rev_l[p]),
               measured_duty(dz_fwd_r[p], dz_rev_r[p]), ref_omega, ref_theta);
    end
    read_sample(az_lo_addr, az_hi_addr, smp);
    check_sample("az", smp, ref_az(ref_theta));
    read_sample(ptch_lo_addr, ptch_hi_addr, smp);
    check_sample("ptch_rate", smp, ref_ptch(ref_omega));
    finish_test("dead zone torque", start);

    ////////////////////////////// INT and setup
    start = err_cnt;
    apply_reset();
    hold_int_low(odr_div + 64, ok);
    require(ok, "INT rose before any setup register was written");
    reg_write(setup_a_addr, setup_a_val);
    hold_int_low(odr_div + 64, ok);
    require(ok, "INT rose with only the first setup register written");
    reg_write(setup_b_addr, setup_b_val);
    wait_int(1'b1, 2 * odr_div, ok);
    require(ok, "INT did not rise after both setup registers were written");
    reg_read(ptch_lo_addr, rd_val);   // this read clears INT
    check_byte("reg 0x22", rd_val, ptch_rt_offset[7:0]);
    wait_int(1'b0, 8, ok);
    require(ok, "INT stayed high after reading 0x22");
    finish_test("INT on setup", start);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: segway_imu.f
+incdir+include
source/segway_phys_pkg.sv
source/imu_pkg.sv
source/reg_bus_if.sv
source/pwm_duty_meter.sv
source/platform_physics.sv
source/imu_spi_slave.sv
source/imu_reg_block.sv
source/segway_imu.sv
bench/tb_segway_imu.sv
